/* vlog.f */
+incdir+verilog
verilog/a2bus_pkg.sv
verilog/a2bus_timing.sv
verilog/a2bus_cycle_monitor.sv
verilog/a2bus_bridge_seq.sv
verilog/a2bus_top.sv
tests/a2bus_properties.sv
tests/a2bus_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the Apple slot front end with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

{ verilator --binary --timing --assert -f vlog.f --top-module a2bus_tb -o a2bus_sim \
    && ./obj_dir/a2bus_sim; } > sim.log 2>&1

cat sim.log
! grep -q "STATUS: FAIL" sim.log && grep -q "STATUS: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tests/a2bus_tb.sv */
// Slot phases come from the defines header and the bridge model answers within the same clock
`timescale 1ns/10ps
`include "a2bus_defines.svh"

module a2bus_tb;

    localparam int NCYC  = 40;
    localparam int PHASE = int'(`A2_PHASE_COUNT);
    localparam int CYCLE = int'(`A2_CYCLE_COUNT);
    localparam int M14   = int'(`A2_14M_COUNT);

    logic                   a2bus_if;
    logic                   arst_n_i;
    logic                   a2_phi1_i;
    logic                   a2_q3_i;
    logic                   a2_7m_i;
    logic [7:0]             a2_bridge_d_i;
    logic                   ready_i;
    logic                   data_out_en_i;
    logic [7:0]             data_out_i;
    logic                   irq_n_i;
    logic                   inh_n_i;
    a2bus_pkg::bridge_drv_t bridge;
    a2bus_pkg::bus_cycle_t  bus_cycle;
    a2bus_pkg::ctrl_lines_t ctrl_in;
    logic                   data_strobe;
    logic                   addr_strobe;
    logic [3:0]             dip_n;
    logic                   sw_gs;
    logic                   sleep;
    logic                   extended_cycle;
    logic                   bus_d_oe_n;

    // Reference model of the slot, one entry per Apple cycle
    logic [15:0] addr_m [0:NCYC-1];
    logic [7:0]  ctrl_m [0:NCYC-1];
    logic [7:0]  m2_m [0:NCYC-1];
    logic [7:0]  data_m [0:NCYC-1];
    logic        stretch_m [0:NCYC-1];
    logic [3:0]  dip_m;
    logic [7:0]  exp_dout;
    logic        exp_en;
    logic [7:0]  exp_ctrl_out;
    logic        gpio_chg;
    int          cur;
    int          seed;
    int          wr_count;
    logic [2:0]  first_wr_sel;
    logic [7:0]  first_wr_d;
    logic        addr_seen;
    logic        data_seen;
    logic        dwr_seen;
    logic        gwr_seen;
    logic        ext_seen;

    a2bus_top i_a2bus_top (
        .a2bus_if         (a2bus_if),
        .arst_n_i         (arst_n_i),
        .a2_phi1_i        (a2_phi1_i),
        .a2_q3_i          (a2_q3_i),
        .a2_7m_i          (a2_7m_i),
        .a2_bridge_d_i    (a2_bridge_d_i),
        .bridge_o         (bridge),
        .ready_i          (ready_i),
        .data_out_en_i    (data_out_en_i),
        .data_out_i       (data_out_i),
        .irq_n_i          (irq_n_i),
        .inh_n_i          (inh_n_i),
        .bus_cycle_o      (bus_cycle),
        .data_strobe_o    (data_strobe),
        .addr_strobe_o    (addr_strobe),
        .ctrl_in_o        (ctrl_in),
        .dip_n_o          (dip_n),
        .sw_gs_o          (sw_gs),
        .sleep_o          (sleep),
        .extended_cycle_o (extended_cycle),
        .bus_d_oe_n_o     (bus_d_oe_n)
    );

    initial begin
        a2bus_if = 1'b0;
        forever #50 a2bus_if = ~a2bus_if;
    end

    // Bridge chip model, it answers whatever select the sequencer shows
    always_comb begin
        case (bridge.sel)
            a2bus_pkg::SEL_CTRL:    a2_bridge_d_i = ctrl_m[cur];
            a2bus_pkg::SEL_DATA:    a2_bridge_d_i = data_m[cur];
            a2bus_pkg::SEL_ADDR_LO: a2_bridge_d_i = addr_m[cur][7:0];
            a2bus_pkg::SEL_ADDR_HI: a2_bridge_d_i = addr_m[cur][15:8];
            a2bus_pkg::SEL_M2:      a2_bridge_d_i = m2_m[cur];
            a2bus_pkg::SEL_DIP:     a2_bridge_d_i = {4'h0, dip_m};
            default:                a2_bridge_d_i = 8'h00;
        endcase
    end

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        string line;
        line = $sformatf("FAILED %s expected %0h actual %0h", name, exp, act);
        assert (exp == act) else abort(line);
    endtask

    // Slot control lines sit in bits 1 to 6 of the control byte
    function automatic logic [5:0] ctrl_fields(input logic [7:0] b);
        return {b[1], b[2], b[3], b[4], b[5], b[6]};
    endfunction

    task automatic tick();
        @(posedge a2bus_if);
        #5;
    endtask

    // Strobes and the write log are sampled mid-clock, away from the edges
    always @(negedge a2bus_if) begin
        if (arst_n_i) begin
            if (addr_strobe) begin
                check_val("addr_capture", 32'(addr_m[cur]), 32'(bus_cycle.addr));
                check_val("rw_capture", 32'(ctrl_m[cur][0]), 32'(bus_cycle.rw_n));
                check_val("m2sel_capture", 32'(m2_m[cur][1] & ~dip_m[3]),
                          32'(bus_cycle.m2sel_n));
                check_val("m2b0_capture", 32'(m2_m[cur][0] & ~dip_m[3]), 32'(bus_cycle.m2b0));
                addr_seen = 1'b1;
            end
            if (data_strobe) begin
                check_val("data_capture", 32'(data_m[cur]), 32'(bus_cycle.data));
                data_seen = 1'b1;
            end
            if (extended_cycle) begin
                ext_seen = 1'b1;
            end
            if (!bridge.wr_n) begin
                if (wr_count == 0) begin
                    first_wr_sel = bridge.sel;
                    first_wr_d   = bridge.d;
                end
                wr_count = wr_count + 1;
                if (bridge.sel == a2bus_pkg::SEL_DATA && bridge.d == exp_dout) begin
                    dwr_seen = 1'b1;
                end
                if (bridge.sel == a2bus_pkg::SEL_CTRL && bridge.d == exp_ctrl_out) begin
                    gwr_seen = 1'b1;
                end
            end
        end
    end

    task automatic close_cycle(input int c);
        if (c >= 2) begin
            check_val("addr_strobe_count", 32'(1), 32'(addr_seen));
            check_val("data_strobe_count", 32'(!(m2_m[c][1] & ~dip_m[3])), 32'(data_seen));
            if (exp_en) begin
                check_val("bus_write_log", 32'(1), 32'(dwr_seen));
            end
            if (gpio_chg) begin
                check_val("gpio_write_log", 32'(1), 32'(gwr_seen));
            end
        end
    endtask

    initial begin
        int   r;
        int   len;
        int   m7_cnt;
        int   waited;
        logic irq_new;
        logic inh_new;
        seed          = 24;
        arst_n_i      = 1'b0;
        a2_phi1_i     = 1'b0;
        a2_q3_i       = 1'b0;
        a2_7m_i       = 1'b0;
        ready_i       = 1'b0;
        data_out_en_i = 1'b0;
        data_out_i    = 8'h00;
        irq_n_i       = 1'b1;
        inh_n_i       = 1'b1;
        cur           = 0;
        wr_count      = 0;
        exp_dout      = 8'h00;
        exp_en        = 1'b0;
        exp_ctrl_out  = 8'hFF;
        gpio_chg      = 1'b0;
        addr_seen     = 1'b0;
        data_seen     = 1'b0;
        dwr_seen      = 1'b0;
        gwr_seen      = 1'b0;
        ext_seen      = 1'b0;
        m7_cnt        = 0;
        for (int i = 0; i < NCYC; i++) begin
            r = $random(seed);
            addr_m[i] = r[15:0];
            ctrl_m[i] = r[23:16];
            m2_m[i]   = r[31:24];
            r = $random(seed);
            data_m[i]    = r[7:0];
            stretch_m[i] = (i >= 2) && (i <= NCYC - 2) && (r[10:8] == 3'd0);
        end
        r = $random(seed);
        // GS stays on so the expansion bits are exercised
        dip_m = {1'b0, r[2:0]};

        repeat (16) @(posedge a2bus_if);
        #5;
        arst_n_i = 1'b1;
        repeat (4) tick();

        for (int c = 0; c < NCYC; c++) begin
            len = CYCLE + (stretch_m[c] ? M14 + 1 : 0);
            for (int j = 0; j < len; j++) begin
                tick();
                if (j == 0) begin
                    if (c > 0) begin
                        close_cycle(c - 1);
                    end
                    cur = c;
                    r = $random(seed);
                    exp_en        = r[0];
                    exp_dout      = r[15:8];
                    data_out_en_i = exp_en;
                    data_out_i    = exp_dout;
                    addr_seen     = 1'b0;
                    data_seen     = 1'b0;
                    dwr_seen      = 1'b0;
                    gwr_seen      = 1'b0;
                    gpio_chg      = 1'b0;
                    if (c == 1) begin
                        ready_i = 1'b1;
                    end
                end
                a2_phi1_i = (j < PHASE);
                a2_q3_i   = ((j % PHASE) < PHASE / 2);
                m7_cnt = m7_cnt + 1;
                if (m7_cnt == M14) begin
                    m7_cnt  = 0;
                    a2_7m_i = ~a2_7m_i;
                end
                if (j == 1) begin
                    check_val("bus_d_oe_n", 32'(!exp_en), 32'(bus_d_oe_n));
                end
                if (j == 8 && c == 1) begin
                    check_val("startup_write_count", 32'(1), 32'(wr_count > 0));
                    check_val("startup_write_sel", 32'(a2bus_pkg::SEL_CTRL), 32'(first_wr_sel));
                    check_val("startup_write_byte", 32'(8'hFF), 32'(first_wr_d));
                    check_val("startup_dip", 32'(dip_m), 32'(dip_n));
                    check_val("startup_sw_gs", 32'(!dip_m[3]), 32'(sw_gs));
                end
                if (j == 10) begin
                    if (c >= 3) begin
                        check_val("extended_cycle", 32'(stretch_m[c - 1]), 32'(ext_seen));
                    end
                    ext_seen = 1'b0;
                end
                if (j == 20 && c >= 2) begin
                    check_val("ctrl_in", 32'(ctrl_fields(ctrl_m[c])), 32'(ctrl_in));
                    check_val("sleep_running", 32'(0), 32'(sleep));
                end
                if (j == 30 && c >= 2) begin
                    r = $random(seed);
                    irq_new = r[0];
                    inh_new = r[1];
                    if (irq_new != irq_n_i || inh_new != inh_n_i) begin
                        gpio_chg = 1'b1;
                    end
                    irq_n_i      = irq_new;
                    inh_n_i      = inh_new;
                    exp_ctrl_out = 8'hFF;
                    exp_ctrl_out[1] = inh_new;
                    exp_ctrl_out[2] = irq_new;
                end
            end
        end
        tick();
        close_cycle(NCYC - 1);

        // PHI1 stops high, so the phase counter must saturate
        a2_phi1_i = 1'b1;
        waited = 0;
        while (!sleep && waited < 200) begin
            tick();
            waited = waited + 1;
        end
        if (!sleep) begin
            abort("sleep_o never rose within 200 clocks after PHI1 stopped");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

/* tests/a2bus_properties.sv */
// Bound into every bridge sequencer and checks only while the asynchronous reset is released
`timescale 1ns/10ps

module a2bus_properties (
    input logic                   a2bus_if,
    input logic                   arst_n_i,
    input a2bus_pkg::bridge_drv_t bridge_o,
    input logic                   addr_strobe_o,
    input logic                   data_strobe_o
);

    // The bridge port is shared, so a read and a write may never overlap
    assert property (@(posedge a2bus_if) disable iff (!arst_n_i)
        !(!bridge_o.wr_n && !bridge_o.rd_n))
        else $error("bridge rd_n and wr_n low together");

    assert property (@(posedge a2bus_if) disable iff (!arst_n_i)
        !bridge_o.wr_n |-> bridge_o.d_oe)
        else $error("bridge wr_n low without d_oe");

    assert property (@(posedge a2bus_if) disable iff (!arst_n_i)
        addr_strobe_o |=> !addr_strobe_o)
        else $error("addr_strobe_o longer than one clock");

    assert property (@(posedge a2bus_if) disable iff (!arst_n_i)
        data_strobe_o |=> !data_strobe_o)
        else $error("data_strobe_o longer than one clock");

endmodule

bind a2bus_bridge_seq a2bus_properties i_a2bus_properties (
    .a2bus_if      (a2bus_if),
    .arst_n_i      (arst_n_i),
    .bridge_o      (bridge_o),
    .addr_strobe_o (addr_strobe_o),
    .data_strobe_o (data_strobe_o)
);

/* verilog/a2bus_top.sv */
// Slot front end for a bridge-chip card and all counts and output enables come from the defines header
`timescale 1ns/10ps
`include "a2bus_defines.svh"

module a2bus_top (
    input  logic                   a2bus_if,
    input  logic                   arst_n_i,
    input  logic                   a2_phi1_i,
    input  logic                   a2_q3_i,
    input  logic                   a2_7m_i,
    input  logic [7:0]             a2_bridge_d_i,
    output a2bus_pkg::bridge_drv_t bridge_o,
    input  logic                   ready_i,
    input  logic                   data_out_en_i,
    input  logic [7:0]             data_out_i,
    input  logic                   irq_n_i,
    input  logic                   inh_n_i,
    output a2bus_pkg::bus_cycle_t  bus_cycle_o,
    output logic                   data_strobe_o,
    output logic                   addr_strobe_o,
    output a2bus_pkg::ctrl_lines_t ctrl_in_o,
    output logic [3:0]             dip_n_o,
    output logic                   sw_gs_o,
    output logic                   sleep_o,
    output logic                   extended_cycle_o,
    output logic                   bus_d_oe_n_o
);

    a2bus_pkg::phase_t phase;
    logic [5:0]        phase_cnt;

    a2bus_timing i_a2bus_timing (
        .a2bus_if  (a2bus_if),
        .arst_n_i  (arst_n_i),
        .a2_phi1_i (a2_phi1_i),
        .a2_q3_i   (a2_q3_i),
        .a2_7m_i   (a2_7m_i),
        .phase_o   (phase)
    );

    a2bus_cycle_monitor i_a2bus_cycle_monitor (
        .a2bus_if         (a2bus_if),
        .arst_n_i         (arst_n_i),
        .phase_i          (phase),
        .phase_cnt_o      (phase_cnt),
        .sleep_o          (sleep_o),
        .extended_cycle_o (extended_cycle_o)
    );

    a2bus_bridge_seq i_a2bus_bridge_seq (
        .a2bus_if      (a2bus_if),
        .arst_n_i      (arst_n_i),
        .phase_i       (phase),
        .phase_cnt_i   (phase_cnt),
        .ready_i       (ready_i),
        .a2_bridge_d_i (a2_bridge_d_i),
        .data_out_en_i (data_out_en_i),
        .data_out_i    (data_out_i),
        .irq_n_i       (irq_n_i),
        .inh_n_i       (inh_n_i),
        .bridge_o      (bridge_o),
        .bus_cycle_o   (bus_cycle_o),
        .addr_strobe_o (addr_strobe_o),
        .data_strobe_o (data_strobe_o),
        .ctrl_in_o     (ctrl_in_o),
        .dip_n_o       (dip_n_o),
        .sw_gs_o       (sw_gs_o)
    );

    // Slot data buffer faces the bus whenever the SoC wants to drive it
    assign bus_d_oe_n_o = ~(data_out_en_i & `A2_BUS_DATA_OUT_EN);

endmodule

/* verilog/a2bus_bridge_seq.sv */
// Bridge must answer reads combinationally within one clock and a late request overwrites a pending one
`timescale 1ns/10ps
`include "a2bus_defines.svh"

module a2bus_bridge_seq (
    input  logic                   a2bus_if,
    input  logic                   arst_n_i,
    input  a2bus_pkg::phase_t      phase_i,
    input  logic [5:0]             phase_cnt_i,
    input  logic                   ready_i,
    input  logic [7:0]             a2_bridge_d_i,
    input  logic                   data_out_en_i,
    input  logic [7:0]             data_out_i,
    input  logic                   irq_n_i,
    input  logic                   inh_n_i,
    output a2bus_pkg::bridge_drv_t bridge_o,
    output a2bus_pkg::bus_cycle_t  bus_cycle_o,
    output logic                   addr_strobe_o,
    output logic                   data_strobe_o,
    output a2bus_pkg::ctrl_lines_t ctrl_in_o,
    output logic [3:0]             dip_n_o,
    output logic                   sw_gs_o
);

    a2bus_pkg::io_state_e   state_q;
    a2bus_pkg::io_state_e   pend_q;
    logic [2:0]             cyc_q;
    a2bus_pkg::bridge_drv_t bridge_q;
    a2bus_pkg::ctrl_lines_t ctrl_in_q;
    logic [7:0]             ctrl_out_q;
    logic [7:0]             prev_ctrl_out_q;
    logic [3:0]             dip_q;
    logic                   addr_strobe_q;
    logic                   data_strobe_q;
    logic                   m2sel_n_q;
    logic                   m2b0_q;
    logic [15:0]            next_addr_q;
    logic                   next_rw_n_q;
    logic [15:0]            addr_q;
    logic                   rw_n_q;
    logic [7:0]             data_q;
    logic                   sw_gs;

    always_ff @(posedge a2bus_if or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q         <= a2bus_pkg::IO_INIT;
            pend_q          <= a2bus_pkg::IO_IDLE;
            cyc_q           <= '0;
            bridge_q.sel    <= a2bus_pkg::SEL_CTRL;
            bridge_q.rd_n   <= 1'b1;
            bridge_q.wr_n   <= 1'b1;
            bridge_q.d      <= '0;
            bridge_q.d_oe   <= 1'b0;
            bridge_q.a_oe_n <= 1'b1;
            ctrl_in_q       <= '1;
            ctrl_out_q      <= 8'hFF;
            prev_ctrl_out_q <= 8'hFF;
            dip_q           <= 4'hF;
            addr_strobe_q   <= 1'b0;
            data_strobe_q   <= 1'b0;
            m2sel_n_q       <= 1'b1;
            m2b0_q          <= 1'b0;
        end else begin
            addr_strobe_q <= 1'b0;
            data_strobe_q <= 1'b0;
            ctrl_out_q    <= 8'hFF;
            ctrl_out_q[1] <= inh_n_i | ~`A2_INH_OUT_EN;
            ctrl_out_q[2] <= irq_n_i | ~`A2_IRQ_OUT_EN;

            case (state_q)
                a2bus_pkg::IO_INIT: begin
                    if (ready_i) begin
                        cyc_q <= cyc_q + 3'd1;
                        case (cyc_q)
                            3'd0: begin
                                bridge_q.sel  <= a2bus_pkg::SEL_CTRL;
                                bridge_q.rd_n <= 1'b1;
                                bridge_q.d    <= 8'hFF;
                                bridge_q.d_oe <= 1'b1;
                            end
                            3'd1: bridge_q.wr_n <= 1'b0;
                            3'd2: begin
                                bridge_q.wr_n <= 1'b1;
                                bridge_q.d_oe <= 1'b0;
                                bridge_q.sel  <= a2bus_pkg::SEL_DIP;
                                bridge_q.rd_n <= 1'b0;
                            end
                            default: begin
                                dip_q         <= a2_bridge_d_i[3:0];
                                bridge_q.sel  <= a2bus_pkg::SEL_CTRL;
                                bridge_q.rd_n <= 1'b1;
                                state_q       <= a2bus_pkg::IO_IDLE;
                                pend_q        <= a2bus_pkg::IO_IDLE;
                            end
                        endcase
                    end
                end
                a2bus_pkg::IO_IDLE: begin
                    cyc_q <= '0;
                    // The bridge shows the control byte from the second idle clock on
                    if ((bridge_q.sel == a2bus_pkg::SEL_CTRL) && !bridge_q.rd_n) begin
                        ctrl_in_q.inh_n   <= a2_bridge_d_i[1];
                        ctrl_in_q.irq_n   <= a2_bridge_d_i[2];
                        ctrl_in_q.rdy_n   <= a2_bridge_d_i[3];
                        ctrl_in_q.dma_n   <= a2_bridge_d_i[4];
                        ctrl_in_q.nmi_n   <= a2_bridge_d_i[5];
                        ctrl_in_q.reset_n <= a2_bridge_d_i[6];
                    end
                    bridge_q.sel  <= a2bus_pkg::SEL_CTRL;
                    bridge_q.rd_n <= 1'b0;
                    bridge_q.wr_n <= 1'b1;
                    if (pend_q != a2bus_pkg::IO_IDLE) begin
                        state_q <= pend_q;
                        pend_q  <= a2bus_pkg::IO_IDLE;
                    end
                end
                a2bus_pkg::IO_READ_ADDR: begin
                    cyc_q <= cyc_q + 3'd1;
                    case (cyc_q)
                        3'd0: bridge_q.sel <= a2bus_pkg::SEL_ADDR_LO;
                        3'd1: bridge_q.sel <= a2bus_pkg::SEL_ADDR_HI;
                        3'd2: bridge_q.sel <= a2bus_pkg::SEL_CTRL;
                        3'd3: bridge_q.sel <= a2bus_pkg::SEL_M2;
                        default: begin
                            m2b0_q        <= a2_bridge_d_i[0];
                            m2sel_n_q     <= a2_bridge_d_i[1];
                            addr_strobe_q <= 1'b1;
                            bridge_q.rd_n <= 1'b1;
                            state_q       <= a2bus_pkg::IO_IDLE;
                        end
                    endcase
                end
                a2bus_pkg::IO_READ_DATA: begin
                    cyc_q <= cyc_q + 3'd1;
                    if (cyc_q == 3'd0) begin
                        bridge_q.sel <= a2bus_pkg::SEL_DATA;
                    end else begin
                        // Only cycles that select this card's expansion space are reported
                        data_strobe_q <= ~bus_cycle_o.m2sel_n;
                        bridge_q.sel  <= a2bus_pkg::SEL_CTRL;
                        bridge_q.rd_n <= 1'b1;
                        state_q       <= a2bus_pkg::IO_IDLE;
                    end
                end
                a2bus_pkg::IO_WRITE_DATA, a2bus_pkg::IO_WRITE_GPIO: begin
                    cyc_q <= cyc_q + 3'd1;
                    case (cyc_q)
                        3'd0: begin
                            if (state_q == a2bus_pkg::IO_WRITE_DATA) begin
                                bridge_q.sel <= a2bus_pkg::SEL_DATA;
                                bridge_q.d   <= data_out_i;
                            end else begin
                                bridge_q.sel <= a2bus_pkg::SEL_CTRL;
                                bridge_q.d   <= ctrl_out_q;
                            end
                            bridge_q.rd_n <= 1'b1;
                            bridge_q.wr_n <= 1'b1;
                            bridge_q.d_oe <= 1'b1;
                        end
                        3'd1: bridge_q.wr_n <= 1'b0;
                        default: begin
                            bridge_q.wr_n <= 1'b1;
                            bridge_q.d_oe <= 1'b0;
                            bridge_q.sel  <= a2bus_pkg::SEL_CTRL;
                            state_q       <= a2bus_pkg::IO_IDLE;
                        end
                    endcase
                end
                default: state_q <= a2bus_pkg::IO_IDLE;
            endcase

            // Placed after the state case so a fresh request beats the slot being emptied
            if (state_q != a2bus_pkg::IO_INIT) begin
                if (phase_i.phi1 && (phase_cnt_i == `A2_READ_COUNT)) begin
                    pend_q <= a2bus_pkg::IO_READ_ADDR;
                end else if (phase_i.phi0 && (phase_cnt_i == `A2_WRITE_COUNT) && data_out_en_i) begin
                    pend_q <= a2bus_pkg::IO_WRITE_DATA;
                end else if (phase_i.phi0 && (phase_cnt_i == `A2_READ_COUNT)) begin
                    pend_q <= a2bus_pkg::IO_READ_DATA;
                end else if ((pend_q == a2bus_pkg::IO_IDLE) && (ctrl_out_q != prev_ctrl_out_q)) begin
                    pend_q          <= a2bus_pkg::IO_WRITE_GPIO;
                    prev_ctrl_out_q <= ctrl_out_q;
                end
            end
        end
    end

    // Captured bus values, each read one clock after its select was set
    always_ff @(posedge a2bus_if) begin
        if (state_q == a2bus_pkg::IO_READ_ADDR) begin
            case (cyc_q)
                3'd1: next_addr_q[7:0]  <= a2_bridge_d_i;
                3'd2: next_addr_q[15:8] <= a2_bridge_d_i;
                3'd3: next_rw_n_q       <= a2_bridge_d_i[0];
                3'd4: begin
                    addr_q <= next_addr_q;
                    rw_n_q <= next_rw_n_q;
                end
                default: ;
            endcase
        end
        if ((state_q == a2bus_pkg::IO_READ_DATA) && (cyc_q == 3'd1)) begin
            data_q <= a2_bridge_d_i;
        end
    end

    assign sw_gs = ~dip_q[3];

    assign bus_cycle_o.addr    = addr_q;
    assign bus_cycle_o.data    = data_q;
    assign bus_cycle_o.rw_n    = rw_n_q;
    assign bus_cycle_o.m2sel_n = m2sel_n_q & sw_gs;
    assign bus_cycle_o.m2b0    = m2b0_q & sw_gs;

    assign bridge_o      = bridge_q;
    assign addr_strobe_o = addr_strobe_q;
    assign data_strobe_o = data_strobe_q;
    assign ctrl_in_o     = ctrl_in_q;
    assign dip_n_o       = dip_q;
    assign sw_gs_o       = sw_gs;

endmodule

/* verilog/a2bus_cycle_monitor.sv */
// Cycle counts assume the logic clock of the defines header and the cycle timer saturates at 127
`timescale 1ns/10ps
`include "a2bus_defines.svh"

module a2bus_cycle_monitor (
    input  logic              a2bus_if,
    input  logic              arst_n_i,
    input  a2bus_pkg::phase_t phase_i,
    output logic [5:0]        phase_cnt_o,
    output logic              sleep_o,
    output logic              extended_cycle_o
);

    logic [5:0] phase_cnt_q;
    logic [6:0] cycle_timer_q;
    logic       extended_q;

    // Position within the current phase, held at 63 when PHI1 stops
    always_ff @(posedge a2bus_if or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase_cnt_q <= '0;
        end else if (phase_i.phi1_rise || phase_i.phi1_fall) begin
            phase_cnt_q <= '0;
        end else if (phase_cnt_q != 6'd63) begin
            phase_cnt_q <= phase_cnt_q + 6'd1;
        end
    end

    always_ff @(posedge a2bus_if or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cycle_timer_q <= '0;
            extended_q    <= 1'b0;
        end else begin
            extended_q <= 1'b0;
            if (phase_i.phi1_rise) begin
                cycle_timer_q <= '0;
                // Timer reads one less than the cycle length here
                extended_q <= (cycle_timer_q >= (`A2_CYCLE_COUNT + `A2_14M_COUNT - 7'd1));
            end else if (cycle_timer_q != 7'd127) begin
                cycle_timer_q <= cycle_timer_q + 7'd1;
            end
        end
    end

    assign phase_cnt_o      = phase_cnt_q;
    assign sleep_o          = &phase_cnt_q;
    assign extended_cycle_o = extended_q;

endmodule

/* verilog/a2bus_timing.sv */
// Slot clock pins are asynchronous and every level and pulse lags its pin by three logic clocks
`timescale 1ns/10ps
`include "a2bus_defines.svh"

module a2bus_timing (
    input  logic              a2bus_if,
    input  logic              arst_n_i,
    input  logic              a2_phi1_i,
    input  logic              a2_q3_i,
    input  logic              a2_7m_i,
    output a2bus_pkg::phase_t phase_o
);

    // Lane 0 is PHI1, lane 1 is Q3, lane 2 is 7M
    logic [2:0] raw;
    logic [2:0] sync1_q;
    logic [2:0] sync2_q;
    logic [2:0] filt_q;
    logic [2:0] filt_d_q;
    logic [2:0] rise;
    logic [2:0] fall;

    assign raw = {a2_7m_i, a2_q3_i, a2_phi1_i};

    always_ff @(posedge a2bus_if or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q  <= '0;
            sync2_q  <= '0;
            filt_q   <= '0;
            filt_d_q <= '0;
        end else begin
            sync1_q <= raw;
            sync2_q <= sync1_q;
            // A new level is taken only once both sync stages agree on it
            for (int i = 0; i < 3; i++) begin
                if (!`A2_DENOISE_EN || (sync2_q[i] == sync1_q[i])) begin
                    filt_q[i] <= sync2_q[i];
                end
            end
            filt_d_q <= filt_q;
        end
    end

    assign rise = filt_q & ~filt_d_q;
    assign fall = ~filt_q & filt_d_q;

    // PHI0 is the complement of PHI1 so its edges swap
    assign phase_o.phi0         = ~filt_q[0];
    assign phase_o.phi1         = filt_q[0];
    assign phase_o.q3           = filt_q[1];
    assign phase_o.clk_7m       = filt_q[2];
    assign phase_o.phi0_rise    = fall[0];
    assign phase_o.phi0_fall    = rise[0];
    assign phase_o.phi1_rise    = rise[0];
    assign phase_o.phi1_fall    = fall[0];
    assign phase_o.q3_rise      = rise[1];
    assign phase_o.q3_fall      = fall[1];
    assign phase_o.clk_7m_rise  = rise[2];
    assign phase_o.clk_7m_fall  = fall[2];

    // 14M ticks on both edges of 7M
    assign phase_o.clk_14m_rise = rise[2] | fall[2];

endmodule

/* verilog/a2bus_pkg.sv */
// Shared types for the slot front end and the bridge port encoding is fixed by the bridge chip
package a2bus_pkg;

    // Bridge port selections. At SEL_CTRL bit 0 of the read byte is R/W
    typedef enum logic [2:0] {
        SEL_CTRL    = 3'd0,
        SEL_DATA    = 3'd1,
        SEL_ADDR_LO = 3'd2,
        SEL_ADDR_HI = 3'd3,
        SEL_M2      = 3'd4,
        SEL_DIP     = 3'd5
    } bridge_sel_e;

    // Sequencer states. IO_WRITE_ADDR and IO_READ_GPIO are reserved
    typedef enum logic [2:0] {
        IO_INIT       = 3'd0,
        IO_IDLE       = 3'd1,
        IO_READ_ADDR  = 3'd2,
        IO_WRITE_ADDR = 3'd3,
        IO_READ_DATA  = 3'd4,
        IO_WRITE_DATA = 3'd5,
        IO_READ_GPIO  = 3'd6,
        IO_WRITE_GPIO = 3'd7
    } io_state_e;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rw_n;
        logic        m2sel_n;
        logic        m2b0;
    } bus_cycle_t;

    typedef struct packed {
        bridge_sel_e sel;
        logic        rd_n;
        logic        wr_n;
        logic [7:0]  d;
        logic        d_oe;
        logic        a_oe_n;
    } bridge_drv_t;

    typedef struct packed {
        logic phi0;
        logic phi1;
        logic q3;
        logic clk_7m;
        logic phi0_rise;
        logic phi0_fall;
        logic phi1_rise;
        logic phi1_fall;
        logic q3_rise;
        logic q3_fall;
        logic clk_7m_rise;
        logic clk_7m_fall;
        logic clk_14m_rise;
    } phase_t;

    // Slot control inputs, all active low
    typedef struct packed {
        logic inh_n;
        logic irq_n;
        logic rdy_n;
        logic dma_n;
        logic nmi_n;
        logic reset_n;
    } ctrl_lines_t;

endpackage

/* verilog/a2bus_defines.svh */
// Fixed for a logic clock near 54 MHz and a standard 1.023 MHz Apple II slot; edit all counts together
`ifndef A2BUS_DEFINES_SVH
`define A2BUS_DEFINES_SVH

// Logic clocks in one full Apple cycle (PHI1 plus PHI0)
`define A2_CYCLE_COUNT 7'd52

// Logic clocks in a single phase
`define A2_PHASE_COUNT 6'd26

// Phase-count value where address or data is sampled through the bridge
`define A2_READ_COUNT 6'd17

// Phase-count value where a bus write to the bridge is started
`define A2_WRITE_COUNT 6'd10

// Logic clocks in one 14M period, used as the stretch margin
`define A2_14M_COUNT 7'd3

// Card drives IRQ and INH through the control-out byte
`define A2_IRQ_OUT_EN 1'b1
`define A2_INH_OUT_EN 1'b1

// Card may drive the data bus during PHI0
`define A2_BUS_DATA_OUT_EN 1'b1

// Two-sample agreement filter on the slot clocks
`define A2_DENOISE_EN 1'b1

`endif
